/* rtl/fir_pkg.sv */
package fir_pkg;

  // Datapath widths
  localparam int unsigned SampleWidth = 16;
  localparam int unsigned CoeffWidth  = 16;  // Low bits of each RAM word
  localparam int unsigned AccWidth    = 40;
  localparam int unsigned TapCntWidth = 8;
  localparam int unsigned ShiftWidth  = 5;

  // Host bus
  localparam int unsigned BusDataWidth = 32;
  localparam int unsigned BusAddrWidth = 12;  // Word address

  // Address map
  localparam logic [BusAddrWidth-1:0] RegBase    = 12'h100;
  localparam logic [BusAddrWidth-1:0] CoeffLimit = 12'h100;

  // Register offsets from RegBase
  localparam logic [1:0] RegCtrl   = 2'd0;
  localparam logic [1:0] RegNtaps  = 2'd1;
  localparam logic [1:0] RegShift  = 2'd2;
  localparam logic [1:0] RegStatus = 2'd3;

  typedef struct packed {
    logic [BusAddrWidth-1:0]   addr;
    logic                      we;
    logic [BusDataWidth-1:0]   wdata;
    logic [BusDataWidth/8-1:0] be;
  } bus_req_t;

  typedef struct packed {
    logic [BusDataWidth-1:0] rdata;
    logic                    err;
  } bus_rsp_t;

  typedef logic signed [SampleWidth-1:0] sample_t;

  typedef struct packed {
    logic                   enable;
    logic                   clear;     // One-cycle pulse, only issued while idle
    logic [TapCntWidth-1:0] ntaps_m1;  // Tap count minus one
    logic [ShiftWidth-1:0]  shift;
  } fir_cfg_t;

endpackage

/* rtl/bus_frontend.sv */
`timescale 1ns/100ps

module bus_frontend import fir_pkg::*; #(
  parameter int unsigned TapAddrWidth = 5
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  bus_req_t                  req_i,
  output logic                      rsp_valid_o,
  input  logic                      rsp_ready_i,
  output bus_rsp_t                  rsp_o,
  output logic                      ram_req_o,
  output logic                      ram_we_o,
  output logic [BusDataWidth/8-1:0] ram_be_o,
  output logic [TapAddrWidth-1:0]   ram_addr_o,
  output logic [BusDataWidth-1:0]   ram_wdata_o,
  input  logic [BusDataWidth-1:0]   ram_rdata_i,
  output logic                      reg_req_o,
  output logic                      reg_we_o,
  output logic [1:0]                reg_addr_o,
  output logic [BusDataWidth-1:0]   reg_wdata_o,
  input  logic [BusDataWidth-1:0]   reg_rdata_i
);

  localparam int unsigned Depth = 2**TapAddrWidth;

  typedef enum logic [1:0] {
    TgtRam,
    TgtReg,
    TgtErr
  } target_e;

  target_e  tgt_q;
  logic     accept, ram_hit, reg_hit;
  logic     pend_q, held_q;  // Response due now / response waiting for ready
  bus_rsp_t rsp_d, rsp_q;

  assign accept  = req_valid_i && req_ready_o;
  assign ram_hit = (req_i.addr < CoeffLimit) && (req_i.addr < BusAddrWidth'(Depth));
  assign reg_hit = (req_i.addr >= RegBase) && (req_i.addr <= RegBase + 3);

  assign ram_req_o   = accept && ram_hit;
  assign ram_we_o    = req_i.we;
  assign ram_be_o    = req_i.be;
  assign ram_addr_o  = req_i.addr[TapAddrWidth-1:0];
  assign ram_wdata_o = req_i.wdata;

  assign reg_req_o   = accept && reg_hit;
  assign reg_we_o    = req_i.we;
  assign reg_addr_o  = 2'(req_i.addr - RegBase);
  assign reg_wdata_o = req_i.wdata;

  // Both targets deliver read data one cycle after the request
  always_comb begin
    rsp_d = '0;
    case (tgt_q)
      TgtRam:  rsp_d.rdata = ram_rdata_i;
      TgtReg:  rsp_d.rdata = reg_rdata_i;
      default: rsp_d.err = 1'b1;  // Unmapped, zero data
    endcase
  end

  assign rsp_valid_o = pend_q || held_q;
  assign rsp_o       = pend_q ? rsp_d : rsp_q;
  assign req_ready_o = !rsp_valid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tgt_q  <= TgtErr;
      pend_q <= 1'b0;
      held_q <= 1'b0;
    end else begin
      pend_q <= accept;
      if (accept) begin
        tgt_q <= ram_hit ? TgtRam : (reg_hit ? TgtReg : TgtErr);
      end
      if (pend_q) begin
        held_q <= !rsp_ready_i;
      end else if (rsp_ready_i) begin
        held_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pend_q) rsp_q <= rsp_d;
  end

  a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o));

endmodule

/* rtl/coeff_dpram.sv */
`timescale 1ns/100ps

module coeff_dpram import fir_pkg::*; #(
  parameter int unsigned TapAddrWidth = 5
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Host port
  input  logic                      a_req_i,
  input  logic                      a_we_i,
  input  logic [BusDataWidth/8-1:0] a_be_i,
  input  logic [TapAddrWidth-1:0]   a_addr_i,
  input  logic [BusDataWidth-1:0]   a_wdata_i,
  output logic [BusDataWidth-1:0]   a_rdata_o,
  // Engine port
  input  logic                      b_en_i,
  input  logic [TapAddrWidth-1:0]   b_addr_i,
  output logic [CoeffWidth-1:0]     b_coeff_o
);

  localparam int unsigned Depth    = 2**TapAddrWidth;
  localparam int unsigned NumBytes = BusDataWidth / 8;

  (* ram_style = "block" *) logic [BusDataWidth-1:0] mem_q [Depth];

  always_ff @(posedge clk_i) begin
    if (a_req_i) begin
      if (a_we_i) begin
        for (int i = 0; i < NumBytes; i++) begin
          if (a_be_i[i]) mem_q[a_addr_i][8*i +: 8] <= a_wdata_i[8*i +: 8];
        end
      end
      a_rdata_o <= mem_q[a_addr_i];  // Read-first, a write returns the old word
    end
  end

  // Coefficient read, low half of the word
  always_ff @(posedge clk_i) begin
    if (b_en_i) b_coeff_o <= mem_q[b_addr_i][CoeffWidth-1:0];
  end

  a_addr_a_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    a_req_i |-> !$isunknown(a_addr_i));

  a_addr_b_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_en_i |-> !$isunknown(b_addr_i));

endmodule

/* rtl/fir_ctrl_regs.sv */
`timescale 1ns/100ps

module fir_ctrl_regs import fir_pkg::*; #(
  parameter int unsigned TapAddrWidth = 5
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  logic                    we_i,
  input  logic [1:0]              addr_i,
  input  logic [BusDataWidth-1:0] wdata_i,
  output logic [BusDataWidth-1:0] rdata_o,
  output fir_cfg_t                cfg_o,
  input  logic                    busy_i
);

  localparam int unsigned MaxTaps = 2**TapAddrWidth;

  logic                    enable_q;
  logic                    clr_pend_q;
  logic                    clr_fire;
  logic [TapCntWidth-1:0]  ntaps_m1_q;
  logic [ShiftWidth-1:0]   shift_q;
  logic [BusDataWidth-1:0] rd_val;

  // Clamp a written tap count into 1..MaxTaps, result is count minus one
  function automatic logic [TapCntWidth-1:0] clamp_taps(logic [BusDataWidth-1:0] val);
    if (val == '0) return '0;
    if (val > BusDataWidth'(MaxTaps)) return TapCntWidth'(MaxTaps - 1);
    return TapCntWidth'(val - 1'b1);
  endfunction

  assign clr_fire = clr_pend_q && !busy_i;  // Held off while a sample is in flight

  assign cfg_o = '{enable: enable_q, clear: clr_fire, ntaps_m1: ntaps_m1_q, shift: shift_q};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q   <= 1'b0;
      clr_pend_q <= 1'b0;
      ntaps_m1_q <= '0;  // NTAPS 1
      shift_q    <= '0;
    end else begin
      if (clr_fire) clr_pend_q <= 1'b0;
      if (req_i && we_i) begin
        case (addr_i)
          RegCtrl: begin
            enable_q <= wdata_i[0];
            if (wdata_i[1]) clr_pend_q <= 1'b1;
          end
          RegNtaps: ntaps_m1_q <= clamp_taps(wdata_i);
          RegShift: shift_q    <= wdata_i[ShiftWidth-1:0];
          default: ;  // STATUS is read-only
        endcase
      end
    end
  end

  always_comb begin
    rd_val = '0;
    case (addr_i)
      RegCtrl:   rd_val[0] = enable_q;  // Clear bit always reads 0
      RegNtaps:  rd_val = BusDataWidth'(ntaps_m1_q) + 1'b1;
      RegShift:  rd_val[ShiftWidth-1:0] = shift_q;
      RegStatus: rd_val[0] = busy_i;
      default:   rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i) rdata_o <= rd_val;
  end

endmodule

/* rtl/fir_mac_engine.sv */
`timescale 1ns/100ps

module fir_mac_engine import fir_pkg::*; #(
  parameter int unsigned TapAddrWidth = 5
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  fir_cfg_t                cfg_i,
  output logic                    busy_o,
  // Coefficient RAM port
  output logic                    coeff_en_o,
  output logic [TapAddrWidth-1:0] coeff_addr_o,
  input  logic [CoeffWidth-1:0]   coeff_i,
  // Sample stream
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  sample_t                 in_data_i,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output sample_t                 out_data_o
);

  localparam int unsigned Depth     = 2**TapAddrWidth;
  localparam int unsigned ProdWidth = SampleWidth + CoeffWidth;
  localparam logic signed [AccWidth-1:0] SatMax = AccWidth'(2**(SampleWidth-1) - 1);
  localparam logic signed [AccWidth-1:0] SatMin = -SatMax - 1;

  typedef enum logic [2:0] {
    StIdle,
    StRun,    // Issuing coefficient reads for taps 1 and up
    StDrain,  // Last product still in flight
    StFinal,  // Shift and saturate
    StOut
  } state_e;

  state_e                      state_q, state_d;
  sample_t                     hist_q [Depth];  // Element 0 is the newest sample
  logic [TapAddrWidth-1:0]     tap_q, last_q, mac_tap_q;
  logic [ShiftWidth-1:0]       shift_q;
  logic                        mac_vld_q;
  logic                        accept;
  logic signed [CoeffWidth-1:0] coeff;
  logic signed [ProdWidth-1:0] prod;
  logic signed [AccWidth-1:0]  acc_q, acc_shr;
  sample_t                     sat, out_q;

  assign accept      = in_valid_i && in_ready_o;
  assign in_ready_o  = cfg_i.enable && !cfg_i.clear && (state_q == StIdle);
  assign busy_o      = (state_q != StIdle);
  assign out_valid_o = (state_q == StOut);
  assign out_data_o  = out_q;

  // Tap 0 is read in the accept cycle so the RAM latency hides behind the history shift
  assign coeff_en_o   = accept || (state_q == StRun);
  assign coeff_addr_o = (state_q == StRun) ? tap_q : '0;

  always_comb begin
    state_d = state_q;
    case (state_q)
      StIdle: begin
        if (accept) state_d = (cfg_i.ntaps_m1 == '0) ? StDrain : StRun;
      end
      StRun: begin
        if (tap_q == last_q) state_d = StDrain;
      end
      StDrain: state_d = StFinal;
      StFinal: state_d = StOut;
      StOut: begin
        if (out_ready_i) state_d = StIdle;
      end
      default: state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= StIdle;
      tap_q     <= '0;
      mac_vld_q <= 1'b0;
      mac_tap_q <= '0;
    end else begin
      state_q   <= state_d;
      mac_vld_q <= coeff_en_o;  // Coefficient arrives one cycle after its address
      mac_tap_q <= coeff_addr_o;
      if (accept) begin
        tap_q <= TapAddrWidth'(1);
      end else if (state_q == StRun) begin
        tap_q <= tap_q + 1'b1;
      end
    end
  end

  // History, zero after reset or clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hist_q <= '{default: '0};
    end else if (cfg_i.clear) begin
      hist_q <= '{default: '0};
    end else if (accept) begin
      hist_q[0] <= in_data_i;
      for (int i = 1; i < Depth; i++) begin
        hist_q[i] <= hist_q[i-1];
      end
    end
  end

  assign coeff = $signed(coeff_i);
  assign prod  = coeff * hist_q[mac_tap_q];

  assign acc_shr = acc_q >>> shift_q;

  always_comb begin
    if (acc_shr > SatMax) begin
      sat = {1'b0, {(SampleWidth-1){1'b1}}};
    end else if (acc_shr < SatMin) begin
      sat = {1'b1, {(SampleWidth-1){1'b0}}};
    end else begin
      sat = acc_shr[SampleWidth-1:0];
    end
  end

  // Tap count and shift are sampled per input, so a host write affects the next one
  always_ff @(posedge clk_i) begin
    if (accept) begin
      last_q  <= cfg_i.ntaps_m1[TapAddrWidth-1:0];
      shift_q <= cfg_i.shift;
      acc_q   <= '0;
    end else if (mac_vld_q) begin
      acc_q <= acc_q + prod;
    end
    if (state_q == StFinal) out_q <= sat;
  end

  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

/* rtl/fir_coeff_top.sv */
`timescale 1ns/100ps

module fir_coeff_top import fir_pkg::*; #(
  parameter int unsigned TapAddrWidth = 5
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Host bus
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  bus_req_t req_i,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  output bus_rsp_t rsp_o,
  // Sample stream
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  sample_t  in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output sample_t  out_data_o
);

  logic                      ram_req, ram_we;
  logic [BusDataWidth/8-1:0] ram_be;
  logic [TapAddrWidth-1:0]   ram_addr;
  logic [BusDataWidth-1:0]   ram_wdata, ram_rdata;
  logic                      reg_req, reg_we;
  logic [1:0]                reg_addr;
  logic [BusDataWidth-1:0]   reg_wdata, reg_rdata;
  fir_cfg_t                  cfg;
  logic                      busy;
  logic                      coeff_en;
  logic [TapAddrWidth-1:0]   coeff_addr;
  logic [CoeffWidth-1:0]     coeff;

  bus_frontend #(.TapAddrWidth(TapAddrWidth)) frontend_i (
    .clk_i, .rst_ni,
    .req_valid_i, .req_ready_o, .req_i,
    .rsp_valid_o, .rsp_ready_i, .rsp_o,
    .ram_req_o(ram_req), .ram_we_o(ram_we), .ram_be_o(ram_be),
    .ram_addr_o(ram_addr), .ram_wdata_o(ram_wdata), .ram_rdata_i(ram_rdata),
    .reg_req_o(reg_req), .reg_we_o(reg_we), .reg_addr_o(reg_addr),
    .reg_wdata_o(reg_wdata), .reg_rdata_i(reg_rdata)
  );

  coeff_dpram #(.TapAddrWidth(TapAddrWidth)) coeff_ram_i (
    .clk_i, .rst_ni,
    .a_req_i(ram_req), .a_we_i(ram_we), .a_be_i(ram_be),
    .a_addr_i(ram_addr), .a_wdata_i(ram_wdata), .a_rdata_o(ram_rdata),
    .b_en_i(coeff_en), .b_addr_i(coeff_addr), .b_coeff_o(coeff)
  );

  fir_ctrl_regs #(.TapAddrWidth(TapAddrWidth)) regs_i (
    .clk_i, .rst_ni,
    .req_i(reg_req), .we_i(reg_we), .addr_i(reg_addr),
    .wdata_i(reg_wdata), .rdata_o(reg_rdata),
    .cfg_o(cfg), .busy_i(busy)
  );

  fir_mac_engine #(.TapAddrWidth(TapAddrWidth)) engine_i (
    .clk_i, .rst_ni,
    .cfg_i(cfg), .busy_o(busy),
    .coeff_en_o(coeff_en), .coeff_addr_o(coeff_addr), .coeff_i(coeff),
    .in_valid_i, .in_ready_o, .in_data_i,
    .out_valid_o, .out_ready_i, .out_data_o
  );

endmodule

/* bench/fir_coeff_tb.sv */
`timescale 1ns/100ps

module fir_coeff_tb import fir_pkg::*; ();

  localparam int Timeout = 200;  // Cycles allowed per handshake

  logic     clk_i, rst_ni;
  logic     req_valid_i, req_ready_o, rsp_valid_o, rsp_ready_i;
  bus_req_t req_i;
  bus_rsp_t rsp_o;
  logic     in_valid_i, in_ready_o, out_valid_o, out_ready_i;
  sample_t  in_data_i, out_data_o;

  int seed = 32'h44eff645;
  bit stall_on;
  bit aborted;
  int err_cnt, test_errs, test_checks;

  fir_coeff_top #(.TapAddrWidth(5)) dut_i (.*);

  always #2 clk_i = ~clk_i;

  // Ready is dropped on about half the cycles while stalls are on
  function automatic bit ready_draw();
    if (!stall_on) return 1'b1;
    return ($random(seed) & 1) != 0;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic note_check(input bit ok);
    test_checks++;
    if (!ok) begin
      test_errs++;
      err_cnt++;
    end
  endtask

  task automatic timeout_hit(input string what);
    $display("Timeout at %0t: no %s handshake within %0d cycles", $time, what, Timeout);
    aborted = 1'b1;
    err_cnt++;
  endtask

  task automatic expect_fields(input int got, input int want, input string cmd);
    if (got != want) begin
      $display("Malformed %s line in the cases file", cmd);
      aborted = 1'b1;
    end
  endtask

  task automatic check_rsp(input string sig, input bus_rsp_t exp, input bus_rsp_t act,
                           input bit with_data);
    if (act.err !== exp.err) begin
      $display("Mismatch at %0t: %s.err expected %0b, got %0b", $time, sig, exp.err, act.err);
    end
    if (with_data && act.rdata !== exp.rdata) begin
      $display("Mismatch at %0t: %s.rdata expected %h, got %h", $time, sig, exp.rdata,
               act.rdata);
    end
    note_check(act.err === exp.err && (!with_data || act.rdata === exp.rdata));
  endtask

  task automatic check_sample(input sample_t exp, input sample_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t: out_data_o expected %0d, got %0d", $time, exp, act);
    end
    note_check(act === exp);
  endtask

  // One bus request, then wait for its response under optional stalls
  task automatic bus_access(input bus_req_t req, input bus_rsp_t exp, input bit with_data);
    int       cycles;
    bus_rsp_t got;
    req_i       = req;
    req_valid_i = 1'b1;
    cycles      = 0;
    while (!req_ready_o && !aborted) begin
      next_cycle();
      cycles++;
      if (cycles > Timeout) timeout_hit("request");
    end
    if (aborted) return;
    next_cycle();  // Accepted on this edge
    req_valid_i = 1'b0;
    rsp_ready_i = ready_draw();
    cycles      = 0;
    while (!(rsp_valid_o && rsp_ready_i) && !aborted) begin
      next_cycle();
      rsp_ready_i = ready_draw();
      cycles++;
      if (cycles > Timeout) timeout_hit("response");
    end
    if (aborted) return;
    got = rsp_o;
    next_cycle();
    rsp_ready_i = 1'b0;
    check_rsp($sformatf("rsp_o[%03h]", req.addr), exp, got, with_data);
  endtask

  task automatic stream_sample(input sample_t din, input sample_t exp);
    int      cycles;
    sample_t got;
    in_data_i  = din;
    in_valid_i = 1'b1;
    cycles     = 0;
    while (!in_ready_o && !aborted) begin
      next_cycle();
      cycles++;
      if (cycles > Timeout) timeout_hit("input sample");
    end
    if (aborted) return;
    next_cycle();
    in_valid_i  = 1'b0;
    out_ready_i = ready_draw();
    cycles      = 0;
    while (!(out_valid_o && out_ready_i) && !aborted) begin
      next_cycle();
      out_ready_i = ready_draw();
      cycles++;
      if (cycles > Timeout) timeout_hit("output sample");
    end
    if (aborted) return;
    got = out_data_o;
    next_cycle();
    out_ready_i = 1'b0;
    check_sample(exp, got);
  endtask

  initial begin
    int          fd, n, flag, tests_ok, tests_bad;
    string       cmd, name, rest;
    logic [31:0] addr, data, be;
    int          err, din, dout;
    bus_req_t    req;
    bus_rsp_t    exp;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b0;
    in_valid_i  = 1'b0;
    in_data_i   = '0;
    out_ready_i = 1'b0;
    tests_ok    = 0;
    tests_bad   = 0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    if (!req_ready_o || rsp_valid_o || out_valid_o || in_ready_o) begin
      $display("Handshake outputs after reset are not in their idle state");
      err_cnt++;
    end

    fd = $fopen("bench/fir_coeff_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open bench/fir_coeff_cases.txt");
      aborted = 1'b1;
    end
    while (!aborted && $fscanf(fd, "%s", cmd) == 1) begin
      if (cmd[0] == "#") begin
        n = $fgets(rest, fd);  // Skip the rest of a comment line
      end else if (cmd == "write") begin
        n = $fscanf(fd, "%h %h %h %d", addr, data, be, err);
        expect_fields(n, 4, cmd);
        req = '{addr: addr[BusAddrWidth-1:0], we: 1'b1, wdata: data, be: be[3:0]};
        exp = '{rdata: '0, err: err[0]};
        if (!aborted) bus_access(req, exp, err[0]);  // An error response carries zero data
      end else if (cmd == "read") begin
        n = $fscanf(fd, "%h %h %d", addr, data, err);
        expect_fields(n, 3, cmd);
        req = '{addr: addr[BusAddrWidth-1:0], we: 1'b0, wdata: '0, be: '0};
        exp = '{rdata: data, err: err[0]};
        if (!aborted) bus_access(req, exp, 1'b1);
      end else if (cmd == "sample") begin
        n = $fscanf(fd, "%d %d", din, dout);
        expect_fields(n, 2, cmd);
        if (!aborted) stream_sample(sample_t'(din), sample_t'(dout));
      end else if (cmd == "stall") begin
        n = $fscanf(fd, "%d", flag);
        expect_fields(n, 1, cmd);
        stall_on = (flag != 0);
      end else if (cmd == "end") begin
        n = $fscanf(fd, "%s", name);
        if (test_errs == 0) begin
          $display("Test %s ok, %0d checks", name, test_checks);
          tests_ok++;
        end else begin
          $display("Test %s FAILED, %0d of %0d checks wrong", name, test_errs, test_checks);
          tests_bad++;
        end
        test_errs   = 0;
        test_checks = 0;
      end else begin
        $display("Unknown command %s in the cases file", cmd);
        aborted = 1'b1;
      end
    end
    if (fd != 0) $fclose(fd);

    $display("Tests ok: %0d, failed: %0d, errors: %0d", tests_ok, tests_bad, err_cnt);
    if (!aborted && err_cnt == 0 && tests_bad == 0 && tests_ok > 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* fir_coeff.f */
rtl/fir_pkg.sv
rtl/bus_frontend.sv
rtl/coeff_dpram.sv
rtl/fir_ctrl_regs.sv
rtl/fir_mac_engine.sv
rtl/fir_coeff_top.sv
bench/fir_coeff_tb.sv

/* Makefile */
TOP = fir_coeff_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f fir_coeff.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

/* bench/fir_coeff_cases.txt */
# write <addr> <wdata> <be> <err> | read <addr> <rdata> <err>   (hex fields, err 0 or 1)
# sample <in> <out> (signed decimal) | stall <0 or 1> | end <test name>
read 100 00000000 0
read 101 00000001 0
read 102 00000000 0
read 103 00000000 0
write 101 00000000 f 0
read 101 00000001 0
write 101 000000c8 f 0
read 101 00000020 0
end reset_and_clamp
write 000 11223344 f 0
write 000 aabbccdd 5 0
read 000 11bb33dd 0
write 000 ff00ff00 a 0
read 000 ffbbffdd 0
end byte_enables
write 000 dead0064 f 0
write 001 0000ff38 f 0
write 002 0000012c f 0
write 003 ffc0fe70 f 0
write 101 00000004 f 0
write 100 00000001 f 0
sample 1 100
sample 0 -200
sample 0 300
sample 0 -400
sample 0 0
end impulse
write 000 00007fff f 0
write 001 00007fff f 0
write 002 00000000 f 0
sample 32767 32767
sample -32768 -32767
sample -32768 -32768
write 100 00000003 f 0
write 000 00000010 f 0
write 001 00000003 f 0
write 102 00000004 f 0
sample 100 100
sample -7 11
sample -50 -52
write 100 00000003 f 0
sample 10 10
end saturate_shift_clear
stall 1
read 001 00000003 0
sample 20 21
sample -1 2
read 102 00000004 0
read 000 00000010 0
stall 0
end random_stalls
write 020 ffffffff f 1
read 020 00000000 1
write 104 ffffffff f 1
read 3ff 00000000 1
read 000 00000010 0
read 003 ffc0fe70 0
read 100 00000001 0
read 101 00000004 0
read 102 00000004 0
end unmapped
